//--- hdl/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes

	// One payload word and one byte length
	localparam int word_bits = 32;
	localparam int len_bits = 16;

	// Per-source buffer, scaled down from the jumbo-frame sizing
	localparam int payload_depth = 32;
	localparam int max_frame_words = 16;
	localparam int header_depth = 4;

	// Pointers carry one extra wrap bit
	localparam int payload_addr_bits = $clog2(payload_depth);
	localparam int header_addr_bits = $clog2(header_depth);

	// Admission needs used words below this, i.e. free words above max_frame_words
	localparam logic [payload_addr_bits:0] room_used_limit =
		(payload_addr_bits + 1)'(payload_depth - max_frame_words);

	////////////////////////////////////////////////////////////////////////////
	// Encodings

	localparam logic [15:0] ethertype_arp = 16'h0806;
	localparam logic [15:0] ethertype_ipv4 = 16'h0800;

	// Source select, ARP wins ties
	localparam logic src_arp = 1'b0;
	localparam logic src_ipv4 = 1'b1;

	// Transmit sequencer states
	localparam logic [2:0] tx_st_idle = 3'd0;
	localparam logic [2:0] tx_st_start = 3'd1;
	localparam logic [2:0] tx_st_body = 3'd2;
	localparam logic [2:0] tx_st_commit = 3'd3;
	localparam logic [2:0] tx_st_gap = 3'd4;

	////////////////////////////////////////////////////////////////////////////
	// Types

	typedef logic [word_bits-1:0] word_t;
	typedef logic [2:0] bytes_t;

	// Header slot, length in the top 16 bits over the destination MAC
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [len_bits-1:0] len;
			logic [47:0] mac;
		} fields;
	} frame_header_u;

endpackage

`default_nettype wire

//--- hdl/frame_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// Frame write side, intake into its packet buffer
interface frame_wr_if;
	logic wr_en;
	eth_tx_pkg::word_t wr_data;
	logic commit;
	eth_tx_pkg::frame_header_u hdr;
	logic rollback;
	// High while a largest frame and one header still fit
	logic room;

	modport intake (output wr_en, output wr_data, output commit, output hdr,
		output rollback, input room);
	modport buffer (input wr_en, input wr_data, input commit, input hdr,
		input rollback, output room);
endinterface

// Frame read side, packet buffer into the transmitter
interface frame_rd_if;
	logic hdr_avail;
	// Head header, valid whenever hdr_avail is high
	eth_tx_pkg::frame_header_u hdr;
	// Registered read data, one cycle behind rd_en
	eth_tx_pkg::word_t rd_data;
	logic rd_en;
	logic pop;

	modport buffer (output hdr_avail, output hdr, output rd_data,
		input rd_en, input pop);
	modport transmitter (input hdr_avail, input hdr, input rd_data,
		output rd_en, output pop);
endinterface

`default_nettype wire

//--- hdl/frame_intake.sv
`timescale 1ns/10ps
`default_nettype none

module frame_intake (
	input wire clk,
	input wire arst_n,
	input wire start,
	input wire data_valid,
	input wire eth_tx_pkg::bytes_t bytes_valid,
	input wire eth_tx_pkg::word_t data,
	input wire commit,
	input wire drop,
	input wire [47:0] dst_mac,
	output logic [15:0] dropped_count,
	frame_wr_if.intake wr
);

	logic active;
	logic admit;
	logic [eth_tx_pkg::len_bits-1:0] frame_len;
	eth_tx_pkg::frame_header_u hdr_word;

	// Start only counts when the buffer can take a whole frame
	assign admit = start && wr.room;

	// Words outside an admitted frame are dropped on the floor
	assign wr.wr_en = data_valid && active;
	assign wr.wr_data = data;
	assign wr.commit = commit && active;
	assign wr.rollback = drop && active;

	// Header word written alongside commit
	always_comb begin
		hdr_word.fields.len = frame_len;
		hdr_word.fields.mac = dst_mac;
	end
	assign wr.hdr = hdr_word;

	////////////////////////////////////////////////////////////////////////////
	// Frame tracking

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			frame_len <= '0;
			dropped_count <= '0;
		end else begin
			// Byte length of the frame so far
			if (wr.wr_en)
				frame_len <= frame_len + {{(eth_tx_pkg::len_bits - 3){1'b0}}, bytes_valid};

			if (commit || drop)
				active <= 1'b0;

			// New frame restarts the length
			if (admit) begin
				active <= 1'b1;
				frame_len <= '0;
			end
			// No room, frame rejected
			else if (start)
				dropped_count <= dropped_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
	input wire clk,
	input wire arst_n,
	frame_wr_if.buffer wr,
	frame_rd_if.buffer rd
);

	// Payload words and header slots
	eth_tx_pkg::word_t payload_mem [eth_tx_pkg::payload_depth];
	logic [63:0] header_mem [eth_tx_pkg::header_depth];

	// Payload pointers, all with a wrap bit
	logic [eth_tx_pkg::payload_addr_bits:0] wr_ptr;
	logic [eth_tx_pkg::payload_addr_bits:0] wr_ptr_next;
	logic [eth_tx_pkg::payload_addr_bits:0] commit_ptr;
	logic [eth_tx_pkg::payload_addr_bits:0] base_ptr;
	logic [eth_tx_pkg::payload_addr_bits:0] rd_ptr;
	logic [eth_tx_pkg::payload_addr_bits:0] used_words;

	// Header queue pointers
	logic [eth_tx_pkg::header_addr_bits:0] hdr_wr_ptr;
	logic [eth_tx_pkg::header_addr_bits:0] hdr_rd_ptr;
	logic [eth_tx_pkg::header_addr_bits:0] used_slots;

	// Head frame size in words
	logic [eth_tx_pkg::len_bits-1:0] head_len;
	logic [eth_tx_pkg::len_bits-1:0] head_words_full;
	logic [eth_tx_pkg::payload_addr_bits:0] head_words;

	assign wr_ptr_next = wr.wr_en ? wr_ptr + 1'b1 : wr_ptr;

	// Round the byte length up to whole words
	assign head_len = rd.hdr.fields.len;
	assign head_words_full = {2'b00, head_len[eth_tx_pkg::len_bits-1:2]} +
		{{(eth_tx_pkg::len_bits - 1){1'b0}}, |head_len[1:0]};
	assign head_words = head_words_full[eth_tx_pkg::payload_addr_bits:0];

	////////////////////////////////////////////////////////////////////////////
	// Occupancy

	// Uncommitted words count as used
	assign used_words = wr_ptr - base_ptr;
	assign used_slots = hdr_wr_ptr - hdr_rd_ptr;

	// Slot queue is full exactly when the wrap bit of the difference is set
	assign wr.room = (used_words < eth_tx_pkg::room_used_limit) &&
		!used_slots[eth_tx_pkg::header_addr_bits];

	assign rd.hdr_avail = (hdr_wr_ptr != hdr_rd_ptr);
	assign rd.hdr.raw = header_mem[hdr_rd_ptr[eth_tx_pkg::header_addr_bits-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// Memories

	always_ff @(posedge clk) begin
		if (wr.wr_en)
			payload_mem[wr_ptr[eth_tx_pkg::payload_addr_bits-1:0]] <= wr.wr_data;
		if (wr.commit)
			header_mem[hdr_wr_ptr[eth_tx_pkg::header_addr_bits-1:0]] <= wr.hdr.raw;
		// Registered read port
		if (rd.rd_en)
			rd.rd_data <= payload_mem[rd_ptr[eth_tx_pkg::payload_addr_bits-1:0]];
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointer control

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			base_ptr <= '0;
			rd_ptr <= '0;
			hdr_wr_ptr <= '0;
			hdr_rd_ptr <= '0;
		end else begin
			// Write side, rollback discards back to the last commit
			if (wr.rollback)
				wr_ptr <= commit_ptr;
			else
				wr_ptr <= wr_ptr_next;

			if (wr.commit) begin
				commit_ptr <= wr_ptr_next;
				hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
			end

			// Pop frees the head frame and parks the reader on the next one
			if (rd.pop) begin
				base_ptr <= base_ptr + head_words;
				rd_ptr <= base_ptr + head_words;
				hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
			end
			else if (rd.rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_transmitter.sv
`timescale 1ns/10ps
`default_nettype none

module frame_transmitter (
	input wire clk,
	input wire arst_n,
	frame_rd_if.transmitter arp,
	frame_rd_if.transmitter ipv4,
	output logic tx_start,
	output logic tx_data_valid,
	output eth_tx_pkg::bytes_t tx_bytes_valid,
	output eth_tx_pkg::word_t tx_data,
	output logic tx_commit,
	output logic [15:0] tx_ethertype,
	output logic [47:0] tx_dst_mac
);

	logic [2:0] state;
	logic sel;
	logic pick;
	logic accept;
	logic emit;
	logic last;
	logic rd_en_q;
	logic rd_valid_q;
	logic [eth_tx_pkg::len_bits-1:0] bytes_left;
	logic [eth_tx_pkg::len_bits-1:0] rd_left;
	logic [eth_tx_pkg::len_bits-1:0] len_m1;
	eth_tx_pkg::frame_header_u head;
	eth_tx_pkg::word_t rd_word;

	// ARP goes first whenever it has a frame waiting
	assign pick = arp.hdr_avail ? eth_tx_pkg::src_arp : eth_tx_pkg::src_ipv4;
	assign head = arp.hdr_avail ? arp.hdr : ipv4.hdr;
	assign accept = (state == eth_tx_pkg::tx_st_idle) && (arp.hdr_avail || ipv4.hdr_avail);
	assign len_m1 = head.fields.len - 1'b1;

	// Word currently coming out of the selected buffer
	assign rd_word = (sel == eth_tx_pkg::src_arp) ? arp.rd_data : ipv4.rd_data;
	assign emit = (state == eth_tx_pkg::tx_st_body) && rd_valid_q;
	assign last = emit && (bytes_left <= 16'd4);

	assign arp.rd_en = rd_en_q && (sel == eth_tx_pkg::src_arp);
	assign ipv4.rd_en = rd_en_q && (sel == eth_tx_pkg::src_ipv4);
	// Pop along with the last word read out
	assign arp.pop = last && (sel == eth_tx_pkg::src_arp);
	assign ipv4.pop = last && (sel == eth_tx_pkg::src_ipv4);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= eth_tx_pkg::tx_st_idle;
			sel <= eth_tx_pkg::src_arp;
			rd_en_q <= 1'b0;
			rd_valid_q <= 1'b0;
			rd_left <= '0;
			bytes_left <= '0;
			tx_start <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_commit <= 1'b0;
		end else begin
			tx_start <= (state == eth_tx_pkg::tx_st_start);
			tx_commit <= (state == eth_tx_pkg::tx_st_commit);
			tx_data_valid <= emit;
			rd_valid_q <= rd_en_q;

			// Read ahead, first word issued right at accept
			if (accept) begin
				rd_en_q <= 1'b1;
				rd_left <= {2'b00, len_m1[eth_tx_pkg::len_bits-1:2]};
			end
			else if (rd_left != '0) begin
				rd_en_q <= 1'b1;
				rd_left <= rd_left - 1'b1;
			end
			else
				rd_en_q <= 1'b0;

			case (state)
				eth_tx_pkg::tx_st_idle: begin
					if (accept) begin
						sel <= pick;
						bytes_left <= head.fields.len;
						state <= eth_tx_pkg::tx_st_start;
					end
				end
				eth_tx_pkg::tx_st_start:
					state <= eth_tx_pkg::tx_st_body;
				eth_tx_pkg::tx_st_body: begin
					if (last) begin
						bytes_left <= '0;
						state <= eth_tx_pkg::tx_st_commit;
					end
					else if (emit)
						bytes_left <= bytes_left - 16'd4;
				end
				eth_tx_pkg::tx_st_commit:
					state <= eth_tx_pkg::tx_st_gap;
				// Second idle cycle before the next start
				default:
					state <= eth_tx_pkg::tx_st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// MAC-side datapath

	always_ff @(posedge clk) begin
		// Held from start through commit
		if (accept) begin
			tx_ethertype <= (pick == eth_tx_pkg::src_arp) ?
				eth_tx_pkg::ethertype_arp : eth_tx_pkg::ethertype_ipv4;
			tx_dst_mac <= head.fields.mac;
		end
		if (emit) begin
			tx_data <= rd_word;
			tx_bytes_valid <= last ? bytes_left[2:0] : 3'd4;
		end
	end

endmodule

`default_nettype wire

//--- hdl/eth_tx_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_arbiter (
	input wire clk,
	input wire arst_n,

	// ARP source
	input wire arp_start,
	input wire arp_data_valid,
	input wire eth_tx_pkg::bytes_t arp_bytes_valid,
	input wire eth_tx_pkg::word_t arp_data,
	input wire arp_commit,
	input wire arp_drop,
	input wire [47:0] arp_dst_mac,
	output wire [15:0] arp_dropped_count,

	// IPv4 source
	input wire ipv4_start,
	input wire ipv4_data_valid,
	input wire eth_tx_pkg::bytes_t ipv4_bytes_valid,
	input wire eth_tx_pkg::word_t ipv4_data,
	input wire ipv4_commit,
	input wire ipv4_drop,
	input wire [47:0] ipv4_dst_mac,
	output wire [15:0] ipv4_dropped_count,

	// MAC side
	output wire tx_start,
	output wire tx_data_valid,
	output wire eth_tx_pkg::bytes_t tx_bytes_valid,
	output wire eth_tx_pkg::word_t tx_data,
	output wire tx_commit,
	output wire [15:0] tx_ethertype,
	output wire [47:0] tx_dst_mac
);

	frame_wr_if arp_wr ();
	frame_wr_if ipv4_wr ();
	frame_rd_if arp_rd ();
	frame_rd_if ipv4_rd ();

	////////////////////////////////////////////////////////////////////////////
	// Per-source intake and buffer

	frame_intake i_arp_intake (
		.clk(clk), .arst_n(arst_n),
		.start(arp_start), .data_valid(arp_data_valid), .bytes_valid(arp_bytes_valid),
		.data(arp_data), .commit(arp_commit), .drop(arp_drop), .dst_mac(arp_dst_mac),
		.dropped_count(arp_dropped_count), .wr(arp_wr.intake)
	);
	frame_buffer i_arp_buffer (.clk(clk), .arst_n(arst_n), .wr(arp_wr.buffer), .rd(arp_rd.buffer));

	frame_intake i_ipv4_intake (
		.clk(clk), .arst_n(arst_n),
		.start(ipv4_start), .data_valid(ipv4_data_valid), .bytes_valid(ipv4_bytes_valid),
		.data(ipv4_data), .commit(ipv4_commit), .drop(ipv4_drop), .dst_mac(ipv4_dst_mac),
		.dropped_count(ipv4_dropped_count), .wr(ipv4_wr.intake)
	);
	frame_buffer i_ipv4_buffer (.clk(clk), .arst_n(arst_n), .wr(ipv4_wr.buffer), .rd(ipv4_rd.buffer));

	// One transmitter drains both buffers
	frame_transmitter i_transmitter (
		.clk(clk), .arst_n(arst_n),
		.arp(arp_rd.transmitter), .ipv4(ipv4_rd.transmitter),
		.tx_start(tx_start), .tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data), .tx_commit(tx_commit),
		.tx_ethertype(tx_ethertype), .tx_dst_mac(tx_dst_mac)
	);

endmodule

`default_nettype wire

//--- test/eth_tx_props.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_props (
	input wire clk,
	input wire arst_n,
	input wire tx_start,
	input wire tx_data_valid,
	input wire tx_commit,
	input wire [2:0] tx_bytes_valid
);

	// Body words never share a cycle with the frame delimiters
	a_valid_alone: assert property (@(posedge clk) disable iff (!arst_n)
		tx_data_valid |-> !tx_start && !tx_commit)
		else $error("tx_data_valid overlaps tx_start or tx_commit");

	// Commit is a single pulse
	a_commit_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		tx_commit |=> !tx_commit)
		else $error("tx_commit held longer than one cycle");

	// Every word carries 1 to 4 bytes
	a_bytes_range: assert property (@(posedge clk) disable iff (!arst_n)
		tx_data_valid |-> (tx_bytes_valid >= 3'd1) && (tx_bytes_valid <= 3'd4))
		else $error("tx_bytes_valid out of range");

endmodule

bind frame_transmitter eth_tx_props i_props (
	.clk(clk), .arst_n(arst_n), .tx_start(tx_start), .tx_data_valid(tx_data_valid),
	.tx_commit(tx_commit), .tx_bytes_valid(tx_bytes_valid)
);

`default_nettype wire

//--- test/eth_tx_checker.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_checker (
	input wire clk,
	input wire arst_n,
	input wire tx_start,
	input wire tx_data_valid,
	input wire eth_tx_pkg::bytes_t tx_bytes_valid,
	input wire eth_tx_pkg::word_t tx_data,
	input wire tx_commit,
	input wire [15:0] tx_ethertype,
	input wire [47:0] tx_dst_mac,
	input wire exp_push,
	input wire exp_word_push,
	input wire exp_src,
	input wire [3:0] exp_test,
	input wire [15:0] exp_len,
	input wire [47:0] exp_mac,
	input wire eth_tx_pkg::word_t exp_word,
	output int error_count,
	output int arp_pending,
	output int ipv4_pending,
	output int arp_done,
	output int ipv4_done
);

	// Expected frames per source packed as {test, len, mac}
	logic [67:0] arp_hdr_q [$];
	logic [67:0] ipv4_hdr_q [$];
	eth_tx_pkg::word_t arp_word_q [$];
	eth_tx_pkg::word_t ipv4_word_q [$];

	// Frame currently open on the MAC side
	logic busy;
	logic cur_src;
	logic [3:0] cur_test;
	logic [47:0] cur_mac;
	int exp_words;
	int exp_last;
	int word_idx;
	int arp_add;
	int ipv4_add;
	int arp_sub;
	int ipv4_sub;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and helpers

	// One word per 4 bytes rounded up and the remainder in the last word
	function automatic void frame_shape(input int len, output int words, output int last_bytes);
		words = (len + 3) / 4;
		last_bytes = len - 4 * (words - 1);
	endfunction

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1: return "arp_13_bytes";
			4'd2: return "ipv4_64_bytes";
			4'd3: return "priority";
			4'd4: return "rollback";
			4'd5: return "rejection";
			default: return "random_mix";
		endcase
	endfunction

	function automatic logic take_header(input logic src, output logic [67:0] h);
		if (src == eth_tx_pkg::src_ipv4) begin
			if (ipv4_hdr_q.size() == 0)
				return 1'b0;
			h = ipv4_hdr_q.pop_front();
		end else begin
			if (arp_hdr_q.size() == 0)
				return 1'b0;
			h = arp_hdr_q.pop_front();
		end
		return 1'b1;
	endfunction

	function automatic logic take_word(input logic src, output eth_tx_pkg::word_t w);
		if (src == eth_tx_pkg::src_ipv4) begin
			if (ipv4_word_q.size() == 0)
				return 1'b0;
			w = ipv4_word_q.pop_front();
		end else begin
			if (arp_word_q.size() == 0)
				return 1'b0;
			w = arp_word_q.pop_front();
		end
		return 1'b1;
	endfunction

	task automatic log_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("Mismatch %s: %s expected %0h actual %0h", test_name(cur_test), what,
			expected, actual);
		error_count++;
	endtask

	task automatic fail_check(input string msg);
		$display("Error: %s", msg);
		error_count++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// MAC-side monitor

	always @(posedge clk) begin
		logic [67:0] h;
		eth_tx_pkg::word_t w;
		int exp_bytes;
		logic [15:0] exp_type;
		if (!arst_n) begin
			busy = 1'b0;
			error_count = 0;
			arp_pending <= 0;
			ipv4_pending <= 0;
			arp_done <= 0;
			ipv4_done <= 0;
		end else begin
			arp_add = 0;
			ipv4_add = 0;
			arp_sub = 0;
			ipv4_sub = 0;

			// Expected frames handed over by the stimulus
			if (exp_push) begin
				if (exp_src == eth_tx_pkg::src_ipv4) begin
					ipv4_hdr_q.push_back({exp_test, exp_len, exp_mac});
					ipv4_add = 1;
				end else begin
					arp_hdr_q.push_back({exp_test, exp_len, exp_mac});
					arp_add = 1;
				end
			end
			if (exp_word_push) begin
				if (exp_src == eth_tx_pkg::src_ipv4)
					ipv4_word_q.push_back(exp_word);
				else
					arp_word_q.push_back(exp_word);
			end

			if (tx_data_valid && (tx_start || tx_commit))
				fail_check("tx_data_valid overlaps tx_start or tx_commit");

			// Ethertype picks the source queue
			if (tx_start) begin
				if (busy)
					fail_check("tx_start came while the previous frame was still open");
				if (tx_ethertype != eth_tx_pkg::ethertype_arp &&
						tx_ethertype != eth_tx_pkg::ethertype_ipv4)
					fail_check($sformatf("tx_start with unknown ethertype %h", tx_ethertype));
				cur_src = (tx_ethertype == eth_tx_pkg::ethertype_ipv4) ?
					eth_tx_pkg::src_ipv4 : eth_tx_pkg::src_arp;
				busy = 1'b1;
				word_idx = 0;
				exp_words = 0;
				exp_last = 0;
				if (!take_header(cur_src, h))
					fail_check("a frame came out with none expected from that source");
				else begin
					cur_test = h[67:64];
					cur_mac = h[47:0];
					frame_shape(int'(h[63:48]), exp_words, exp_last);
					if (tx_dst_mac !== cur_mac)
						log_mismatch("tx_dst_mac", cur_mac, tx_dst_mac);
				end
			end

			if (tx_data_valid) begin
				word_idx++;
				if (!busy)
					fail_check("tx_data_valid outside a frame");
				else if (word_idx > exp_words)
					fail_check("frame carries more words than its length allows");
				else if (!take_word(cur_src, w))
					fail_check("a data word came out with no expected word queued");
				else begin
					exp_bytes = (word_idx == exp_words) ? exp_last : 4;
					if (tx_data !== w)
						log_mismatch($sformatf("tx_data word %0d", word_idx), w, tx_data);
					if (tx_bytes_valid !== 3'(exp_bytes))
						log_mismatch($sformatf("tx_bytes_valid word %0d", word_idx),
							exp_bytes, tx_bytes_valid);
					// MAC and ethertype stay put for the whole frame
					if (tx_dst_mac !== cur_mac)
						log_mismatch("tx_dst_mac held", cur_mac, tx_dst_mac);
					exp_type = (cur_src == eth_tx_pkg::src_ipv4) ?
						eth_tx_pkg::ethertype_ipv4 : eth_tx_pkg::ethertype_arp;
					if (tx_ethertype !== exp_type)
						log_mismatch("tx_ethertype held", exp_type, tx_ethertype);
				end
			end

			if (tx_commit) begin
				if (!busy)
					fail_check("tx_commit outside a frame");
				else begin
					if (word_idx != exp_words)
						log_mismatch("word count", exp_words, word_idx);
					// Skip words a short frame left behind so the next one lines up
					while (word_idx < exp_words) begin
						void'(take_word(cur_src, w));
						word_idx++;
					end
					busy = 1'b0;
					if (cur_src == eth_tx_pkg::src_ipv4)
						ipv4_sub = 1;
					else
						arp_sub = 1;
				end
			end

			arp_pending <= arp_pending + arp_add - arp_sub;
			ipv4_pending <= ipv4_pending + ipv4_add - ipv4_sub;
			arp_done <= arp_done + arp_sub;
			ipv4_done <= ipv4_done + ipv4_sub;
		end
	end

endmodule

`default_nettype wire

//--- test/eth_tx_arbiter_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_arbiter_tb;

	localparam int mix_frames = 40;
	// Byte lengths of the directed frames used in the run budget
	localparam int fixed_len [10] = '{13, 64, 60, 4, 6, 24, 30, 64, 20, 64};

	logic clk;
	logic arst_n;

	// Source inputs indexed 0 for ARP and 1 for IPv4
	logic [1:0] src_start;
	logic [1:0] src_valid;
	logic [1:0] src_commit;
	logic [1:0] src_drop;
	eth_tx_pkg::bytes_t src_bytes [2];
	eth_tx_pkg::word_t src_data [2];
	logic [47:0] src_mac [2];
	wire [15:0] arp_dropped_count;
	wire [15:0] ipv4_dropped_count;

	// MAC side
	wire tx_start;
	wire tx_data_valid;
	wire eth_tx_pkg::bytes_t tx_bytes_valid;
	wire eth_tx_pkg::word_t tx_data;
	wire tx_commit;
	wire [15:0] tx_ethertype;
	wire [47:0] tx_dst_mac;

	// Expected frames into the checker
	logic exp_push;
	logic exp_word_push;
	logic exp_src;
	logic [3:0] exp_test;
	logic [15:0] exp_len;
	logic [47:0] exp_mac;
	eth_tx_pkg::word_t exp_word;
	int check_errors;
	int arp_pending;
	int ipv4_pending;
	int arp_done;
	int ipv4_done;

	int tb_errors;
	int cycle_count;
	int cycle_limit;
	int exp_arp_drops;
	int exp_ipv4_drops;
	logic mix_src [mix_frames];
	int mix_len [mix_frames];
	int mix_gap [mix_frames];

	eth_tx_arbiter i_dut (
		.clk(clk), .arst_n(arst_n),
		.arp_start(src_start[0]), .arp_data_valid(src_valid[0]),
		.arp_bytes_valid(src_bytes[0]), .arp_data(src_data[0]),
		.arp_commit(src_commit[0]), .arp_drop(src_drop[0]), .arp_dst_mac(src_mac[0]),
		.arp_dropped_count(arp_dropped_count),
		.ipv4_start(src_start[1]), .ipv4_data_valid(src_valid[1]),
		.ipv4_bytes_valid(src_bytes[1]), .ipv4_data(src_data[1]),
		.ipv4_commit(src_commit[1]), .ipv4_drop(src_drop[1]), .ipv4_dst_mac(src_mac[1]),
		.ipv4_dropped_count(ipv4_dropped_count),
		.tx_start(tx_start), .tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data), .tx_commit(tx_commit),
		.tx_ethertype(tx_ethertype), .tx_dst_mac(tx_dst_mac)
	);

	eth_tx_checker i_checker (
		.clk(clk), .arst_n(arst_n),
		.tx_start(tx_start), .tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data), .tx_commit(tx_commit),
		.tx_ethertype(tx_ethertype), .tx_dst_mac(tx_dst_mac),
		.exp_push(exp_push), .exp_word_push(exp_word_push), .exp_src(exp_src),
		.exp_test(exp_test), .exp_len(exp_len), .exp_mac(exp_mac), .exp_word(exp_word),
		.error_count(check_errors), .arp_pending(arp_pending), .ipv4_pending(ipv4_pending),
		.arp_done(arp_done), .ipv4_done(ipv4_done)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Words on the wire plus start, commit, gap and queueing slack
	function automatic int frame_budget(input int len);
		return 2 * ((len + 3) / 4) + 40;
	endfunction

	function automatic logic [47:0] random_mac();
		logic [47:0] mac;
		mac[47:32] = 16'($urandom);
		mac[31:0] = $urandom;
		return mac;
	endfunction

	function automatic int pending_of(input logic src);
		return (src == eth_tx_pkg::src_ipv4) ? ipv4_pending : arp_pending;
	endfunction

	// Start then one word per cycle then commit or drop
	task automatic send_frame(input logic src, input int len, input logic [47:0] mac,
			input logic do_drop, input logic expect_out, input logic [3:0] test_id);
		int words;
		int i;
		eth_tx_pkg::word_t w;
		words = (len + 3) / 4;
		@(posedge clk);
		src_start[src] <= 1'b1;
		src_mac[src] <= mac;
		for (i = 0; i < words; i++) begin
			@(posedge clk);
			src_start[src] <= 1'b0;
			w = $urandom;
			src_valid[src] <= 1'b1;
			src_data[src] <= w;
			src_bytes[src] <= (i == words - 1) ? eth_tx_pkg::bytes_t'(len - 4 * i) : 3'd4;
			exp_word_push <= expect_out;
			exp_src <= src;
			exp_word <= w;
		end
		@(posedge clk);
		src_valid[src] <= 1'b0;
		exp_word_push <= 1'b0;
		if (do_drop)
			src_drop[src] <= 1'b1;
		else
			src_commit[src] <= 1'b1;
		exp_push <= expect_out;
		exp_src <= src;
		exp_test <= test_id;
		exp_len <= 16'(len);
		exp_mac <= mac;
		@(posedge clk);
		src_drop[src] <= 1'b0;
		src_commit[src] <= 1'b0;
		exp_push <= 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(posedge clk);
		while (arp_pending != 0 || ipv4_pending != 0);
	endtask

	task automatic check_dropped(input string name, input logic [15:0] actual,
			input int expected);
		if (actual != 16'(expected)) begin
			$display("Mismatch rejection: %s dropped_count expected %0d actual %0d",
				name, expected, actual);
			tb_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run limit

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycle_limit);
			$display("Errors: checker %0d, testbench %0d", check_errors, tb_errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int n;
		int seed;
		int arp_base;
		int ipv4_base;
		seed = $urandom(4036);
		clk = 1'b0;
		arst_n = 1'b0;
		src_start = '0;
		src_valid = '0;
		src_commit = '0;
		src_drop = '0;
		src_bytes = '{default: '0};
		src_data = '{default: '0};
		src_mac = '{default: '0};
		exp_push = 1'b0;
		exp_word_push = 1'b0;
		exp_src = 1'b0;
		exp_test = '0;
		exp_len = '0;
		exp_mac = '0;
		exp_word = '0;
		tb_errors = 0;
		cycle_count = 0;
		exp_arp_drops = 0;
		exp_ipv4_drops = 0;

		// Random mix drawn up front so the budget covers it
		cycle_limit = 30;
		for (n = 0; n < 10; n++)
			cycle_limit += frame_budget(fixed_len[n]);
		for (n = 0; n < mix_frames; n++) begin
			mix_src[n] = 1'($urandom % 2);
			mix_len[n] = 1 + int'($urandom % 64);
			mix_gap[n] = int'($urandom % 7);
			cycle_limit += frame_budget(mix_len[n]) + mix_gap[n];
		end

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		// Short ARP frame with 1 byte in the last word
		send_frame(eth_tx_pkg::src_arp, 13, 48'h02_00_5e_00_0a_01, 1'b0, 1'b1, 4'd1);
		wait_drained();

		// Full IPv4 frame
		send_frame(eth_tx_pkg::src_ipv4, 64, 48'h02_00_5e_00_0b_02, 1'b0, 1'b1, 4'd2);
		wait_drained();

		// ARP overtakes an IPv4 frame queued earlier
		arp_base = arp_done;
		ipv4_base = ipv4_done;
		send_frame(eth_tx_pkg::src_ipv4, 60, random_mac(), 1'b0, 1'b1, 4'd3);
		do
			@(posedge clk);
		while (!tx_start);
		send_frame(eth_tx_pkg::src_ipv4, 4, random_mac(), 1'b0, 1'b1, 4'd3);
		send_frame(eth_tx_pkg::src_arp, 6, random_mac(), 1'b0, 1'b1, 4'd3);
		do
			@(posedge clk);
		while (arp_done == arp_base);
		if (ipv4_done != ipv4_base + 1) begin
			$display("Mismatch priority: ipv4 frames ahead of ARP expected %0d actual %0d",
				1, ipv4_done - ipv4_base);
			tb_errors++;
		end
		wait_drained();

		// Dropped frame leaves no trace
		send_frame(eth_tx_pkg::src_ipv4, 24, random_mac(), 1'b1, 1'b0, 4'd4);
		send_frame(eth_tx_pkg::src_ipv4, 30, random_mac(), 1'b0, 1'b1, 4'd4);
		wait_drained();

		// A full frame still unsent leaves no room for another start
		send_frame(eth_tx_pkg::src_ipv4, 64, random_mac(), 1'b0, 1'b1, 4'd5);
		send_frame(eth_tx_pkg::src_ipv4, 20, random_mac(), 1'b0, 1'b0, 4'd5);
		exp_ipv4_drops++;
		wait_drained();
		send_frame(eth_tx_pkg::src_ipv4, 64, random_mac(), 1'b0, 1'b1, 4'd5);
		wait_drained();

		// Random mix with at most one frame per source in the buffer
		for (n = 0; n < mix_frames; n++) begin
			do
				@(posedge clk);
			while (pending_of(mix_src[n]) != 0);
			repeat (mix_gap[n]) @(posedge clk);
			send_frame(mix_src[n], mix_len[n], random_mac(), 1'b0, 1'b1, 4'd6);
		end
		wait_drained();
		repeat (4) @(posedge clk);

		check_dropped("arp", arp_dropped_count, exp_arp_drops);
		check_dropped("ipv4", ipv4_dropped_count, exp_ipv4_drops);

		$display("Errors: checker %0d, testbench %0d", check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/eth_tx_pkg.sv
hdl/frame_bus_if.sv
hdl/frame_intake.sv
hdl/frame_buffer.sv
hdl/frame_transmitter.sv
hdl/eth_tx_arbiter.sv
test/eth_tx_props.sv
test/eth_tx_checker.sv
test/eth_tx_arbiter_tb.sv

//--- Makefile
# Verilator build and run for the Ethernet transmit arbiter

VERILATOR ?= verilator
TOP ?= eth_tx_arbiter_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Result: PASSED
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides, the simulator exit status does not
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
